// ==== source/tcdm_pkg.sv ====
/*
 * Shared definitions of the TCDM transmit unit
 *   widths, lane count and queue depths
 *   command, beat, completion and read response structs
 *   unpacker and lane FSM state enums
 */
package tcdm_pkg;

  //********************************************************************
  // Widths and sizes
  //********************************************************************
  localparam int SID_W       = 2;
  localparam int ADDR_W      = 12;
  localparam int LEN_W       = 4;
  localparam int DATA_W      = 32;
  localparam int NUM_LANES   = 2;
  localparam int QUEUE_DEPTH = 2;
  // Completions a lane may have waiting for its partner lane
  localparam int SYNCH_DEPTH = 4;

  //********************************************************************
  // Structs
  //********************************************************************

  // Transfer command, len counts beat pairs (one word per lane)
  typedef struct packed {
    logic [SID_W-1:0]  sid;
    logic [ADDR_W-1:0] add;
    logic [LEN_W-1:0]  len;
  } tx_cmd_t;

  // One word read for a single lane
  typedef struct packed {
    logic [SID_W-1:0]  sid;
    logic [ADDR_W-1:0] add;
    logic              eop;
  } beat_t;

  typedef struct packed {
    logic             req;
    logic [SID_W-1:0] sid;
  } synch_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } tcdm_rsp_t;

  //********************************************************************
  // FSM states
  //********************************************************************
  typedef enum logic {
    UNPACK_IDLE,
    UNPACK_SPLIT
  } unpack_state_e;

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_REQ,
    LANE_WAIT_RDATA,
    LANE_SEND
  } lane_state_e;

endpackage

// ==== source/tcdm_fifo.sv ====
/*
 * Queue without fall-through, generic in stored type and depth
 * Read and write pointers plus an occupancy counter
 */
`timescale 1ns/1ns

module tcdm_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The producer and consumer must respect the flags
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("tcdm_fifo: push while full");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("tcdm_fifo: pop while empty");

endmodule

// ==== source/tcdm_cmd_unpack.sv ====
/*
 * Command unpacker of the transmit path
 * Splits a transfer command into word beat pairs, one beat per lane,
 * and marks the last pair with eop
 */
`timescale 1ns/1ns

module tcdm_cmd_unpack (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  tcdm_pkg::tx_cmd_t                cmd_i,
  input  logic                             cmd_valid_i,
  output logic                             cmd_pop_o,
  output tcdm_pkg::beat_t                  beat_o [tcdm_pkg::NUM_LANES],
  output logic                             beat_valid_o,
  input  logic [tcdm_pkg::NUM_LANES-1:0]   beat_ready_i
);

  tcdm_pkg::unpack_state_e          state_q;
  tcdm_pkg::tx_cmd_t                cmd_q;
  logic [tcdm_pkg::LEN_W-1:0]       pair_q;
  logic [tcdm_pkg::ADDR_W-1:0]      pair_off;
  logic                             last_pair;

  // A pair spans two words, so its byte offset is pair * 8
  assign pair_off  = {{(tcdm_pkg::ADDR_W - tcdm_pkg::LEN_W - 3){1'b0}}, pair_q, 3'b000};
  assign last_pair = (pair_q == cmd_q.len - 1'b1);

  // Both beats of a pair go out together, only when both lanes have room
  assign beat_valid_o = (state_q == tcdm_pkg::UNPACK_SPLIT) && (&beat_ready_i);

  // Next command is taken in IDLE or right with the last pair of the current one
  assign cmd_pop_o = cmd_valid_i &&
                     ((state_q == tcdm_pkg::UNPACK_IDLE) || (beat_valid_o && last_pair));

  for (genvar k = 0; k < tcdm_pkg::NUM_LANES; k++) begin : g_beat
    assign beat_o[k].sid = cmd_q.sid;
    assign beat_o[k].add = cmd_q.add + pair_off + tcdm_pkg::ADDR_W'(4 * k);
    assign beat_o[k].eop = last_pair;
  end

  //********************************************************************
  // Split FSM
  //********************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= tcdm_pkg::UNPACK_IDLE;
      pair_q  <= '0;
    end else begin
      if (cmd_pop_o) begin
        state_q <= tcdm_pkg::UNPACK_SPLIT;
        pair_q  <= '0;
      end else if (beat_valid_o) begin
        if (last_pair) begin
          state_q <= tcdm_pkg::UNPACK_IDLE;
        end else begin
          pair_q <= pair_q + 1'b1;
        end
      end
    end
  end

  // Current command
  always_ff @(posedge clk_i) begin
    if (cmd_pop_o) begin
      cmd_q <= cmd_i;
    end
  end

  // A zero length command would never produce an eop pair
  assert property (@(posedge clk_i) disable iff (!rst_n_i) cmd_pop_o |-> (cmd_i.len != '0))
    else $error("tcdm_cmd_unpack: command with zero length");

endmodule

// ==== source/tcdm_tx_lane.sv ====
/*
 * Transmit read lane
 * Beat queue and read FSM: one TCDM read per beat, the word is then
 * forwarded on the data stream, eop beats report a completion
 */
`timescale 1ns/1ns

module tcdm_tx_lane (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  tcdm_pkg::beat_t               beat_i,
  input  logic                          beat_valid_i,
  output logic                          beat_ready_o,
  output logic                          tcdm_req_o,
  output logic [tcdm_pkg::ADDR_W-1:0]   tcdm_add_o,
  input  logic                          tcdm_gnt_i,
  input  tcdm_pkg::tcdm_rsp_t           tcdm_rsp_i,
  output logic [tcdm_pkg::DATA_W-1:0]   tx_data_dat_o,
  output logic                          tx_data_req_o,
  input  logic                          tx_data_gnt_i,
  output tcdm_pkg::synch_t              done_o,
  input  logic                          done_ready_i
);

  tcdm_pkg::lane_state_e          state_q;
  tcdm_pkg::lane_state_e          state_d;
  tcdm_pkg::beat_t                queue_beat;
  tcdm_pkg::beat_t                beat_q;
  logic                           queue_full;
  logic                           queue_empty;
  logic                           queue_pop;
  logic [tcdm_pkg::DATA_W-1:0]    rdata_q;
  logic                           sent_q;
  logic                           stream_done;
  logic                           leave_send;

  //********************************************************************
  // Beat queue
  //********************************************************************
  assign beat_ready_o = !queue_full;
  assign queue_pop    = (state_q == tcdm_pkg::LANE_IDLE) && !queue_empty;

  tcdm_fifo #(
    .T     (tcdm_pkg::beat_t),
    .DEPTH (tcdm_pkg::QUEUE_DEPTH)
  ) i_beat_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (beat_valid_i && beat_ready_o),
    .data_i  (beat_i),
    .pop_i   (queue_pop),
    .data_o  (queue_beat),
    .full_o  (queue_full),
    .empty_o (queue_empty)
  );

  //********************************************************************
  // Read FSM
  //********************************************************************
  assign tcdm_req_o    = (state_q == tcdm_pkg::LANE_REQ);
  assign tcdm_add_o    = beat_q.add;
  assign tx_data_req_o = (state_q == tcdm_pkg::LANE_SEND) && !sent_q;
  assign tx_data_dat_o = rdata_q;

  // Word handed over now or earlier; eop beats also need room in the synchroniser
  assign stream_done = sent_q || (tx_data_req_o && tx_data_gnt_i);
  assign leave_send  = (state_q == tcdm_pkg::LANE_SEND) && stream_done &&
                       (!beat_q.eop || done_ready_i);

  always_comb begin
    done_o.req = (state_q == tcdm_pkg::LANE_SEND) && beat_q.eop && stream_done && done_ready_i;
    done_o.sid = beat_q.sid;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      tcdm_pkg::LANE_IDLE:       if (!queue_empty)      state_d = tcdm_pkg::LANE_REQ;
      tcdm_pkg::LANE_REQ:        if (tcdm_gnt_i)        state_d = tcdm_pkg::LANE_WAIT_RDATA;
      tcdm_pkg::LANE_WAIT_RDATA: if (tcdm_rsp_i.valid)  state_d = tcdm_pkg::LANE_SEND;
      tcdm_pkg::LANE_SEND:       if (leave_send)        state_d = tcdm_pkg::LANE_IDLE;
      default:                   state_d = tcdm_pkg::LANE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= tcdm_pkg::LANE_IDLE;
      sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      sent_q  <= stream_done && (state_q == tcdm_pkg::LANE_SEND) && !leave_send;
    end
  end

  // Beat in flight and its read data
  always_ff @(posedge clk_i) begin
    if (queue_pop) begin
      beat_q <= queue_beat;
    end
    if ((state_q == tcdm_pkg::LANE_WAIT_RDATA) && tcdm_rsp_i.valid) begin
      rdata_q <= tcdm_rsp_i.rdata;
    end
  end

  // TCDM port rules
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tcdm_req_o && !tcdm_gnt_i) |=> (tcdm_req_o && $stable(tcdm_add_o)))
    else $error("tcdm_tx_lane: request changed before grant");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == tcdm_pkg::LANE_IDLE) |-> !tcdm_rsp_i.valid)
    else $error("tcdm_tx_lane: response without outstanding read");

endmodule

// ==== source/tcdm_synch.sv ====
/*
 * Completion synchroniser
 * Queues the eop completions of each lane and pulses one synch
 * when every lane has finished the same command
 */
`timescale 1ns/1ns

module tcdm_synch (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  tcdm_pkg::synch_t                 done_i [tcdm_pkg::NUM_LANES],
  output logic [tcdm_pkg::NUM_LANES-1:0]   done_ready_o,
  output tcdm_pkg::synch_t                 synch_o
);

  logic [tcdm_pkg::SID_W-1:0]       head_sid [tcdm_pkg::NUM_LANES];
  logic [tcdm_pkg::NUM_LANES-1:0]   full;
  logic [tcdm_pkg::NUM_LANES-1:0]   empty;
  logic                             all_done;
  tcdm_pkg::synch_t                 synch_q;

  // All lanes hold a completion, so the oldest command is finished
  assign all_done = ~|empty;

  for (genvar k = 0; k < tcdm_pkg::NUM_LANES; k++) begin : g_lane
    assign done_ready_o[k] = !full[k];

    tcdm_fifo #(
      .T     (logic [tcdm_pkg::SID_W-1:0]),
      .DEPTH (tcdm_pkg::SYNCH_DEPTH)
    ) i_sid_queue (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (done_i[k].req),
      .data_i  (done_i[k].sid),
      .pop_i   (all_done),
      .data_o  (head_sid[k]),
      .full_o  (full[k]),
      .empty_o (empty[k])
    );
  end

  // Registered pulse, one cycle after the queues line up
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      synch_q <= '0;
    end else begin
      synch_q.req <= all_done;
      synch_q.sid <= head_sid[0];
    end
  end

  assign synch_o = synch_q;

  // Lanes receive the commands in the same order, so heads must agree
  for (genvar k = 1; k < tcdm_pkg::NUM_LANES; k++) begin : g_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      all_done |-> (head_sid[k] == head_sid[0]))
      else $error("tcdm_synch: lanes completed different commands");
  end

endmodule

// ==== source/tcdm_tx_unit.sv ====
/*
 * Transmit half of the DMA TCDM unit
 * Command queue, unpacker, two read lanes and completion synchroniser
 */
`timescale 1ns/1ns

module tcdm_tx_unit (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  tcdm_pkg::tx_cmd_t                                   cmd_i,
  input  logic                                                cmd_req_i,
  output logic                                                cmd_gnt_o,
  output logic [tcdm_pkg::NUM_LANES-1:0]                      tcdm_req_o,
  output logic [tcdm_pkg::NUM_LANES-1:0][tcdm_pkg::ADDR_W-1:0] tcdm_add_o,
  input  logic [tcdm_pkg::NUM_LANES-1:0]                      tcdm_gnt_i,
  input  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NUM_LANES-1:0]       tcdm_rsp_i,
  output logic [tcdm_pkg::NUM_LANES-1:0][tcdm_pkg::DATA_W-1:0] tx_data_dat_o,
  output logic [tcdm_pkg::NUM_LANES-1:0]                      tx_data_req_o,
  input  logic [tcdm_pkg::NUM_LANES-1:0]                      tx_data_gnt_i,
  output tcdm_pkg::synch_t                                    synch_o
);

  tcdm_pkg::tx_cmd_t                cmd_head;
  logic                             cmd_full;
  logic                             cmd_empty;
  logic                             cmd_pop;
  tcdm_pkg::beat_t                  beats [tcdm_pkg::NUM_LANES];
  logic                             beat_valid;
  logic [tcdm_pkg::NUM_LANES-1:0]   beat_ready;
  tcdm_pkg::synch_t                 lane_done [tcdm_pkg::NUM_LANES];
  logic [tcdm_pkg::NUM_LANES-1:0]   done_ready;

  //********************************************************************
  // Command queue
  //********************************************************************
  assign cmd_gnt_o = !cmd_full;

  tcdm_fifo #(
    .T     (tcdm_pkg::tx_cmd_t),
    .DEPTH (tcdm_pkg::QUEUE_DEPTH)
  ) i_cmd_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (cmd_req_i && cmd_gnt_o),
    .data_i  (cmd_i),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .full_o  (cmd_full),
    .empty_o (cmd_empty)
  );

  tcdm_cmd_unpack i_cmd_unpack (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (cmd_head),
    .cmd_valid_i  (!cmd_empty),
    .cmd_pop_o    (cmd_pop),
    .beat_o       (beats),
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready)
  );

  //********************************************************************
  // Read lanes
  //********************************************************************
  for (genvar k = 0; k < tcdm_pkg::NUM_LANES; k++) begin : g_lane
    tcdm_tx_lane i_tx_lane (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .beat_i        (beats[k]),
      .beat_valid_i  (beat_valid),
      .beat_ready_o  (beat_ready[k]),
      .tcdm_req_o    (tcdm_req_o[k]),
      .tcdm_add_o    (tcdm_add_o[k]),
      .tcdm_gnt_i    (tcdm_gnt_i[k]),
      .tcdm_rsp_i    (tcdm_rsp_i[k]),
      .tx_data_dat_o (tx_data_dat_o[k]),
      .tx_data_req_o (tx_data_req_o[k]),
      .tx_data_gnt_i (tx_data_gnt_i[k]),
      .done_o        (lane_done[k]),
      .done_ready_i  (done_ready[k])
    );
  end

  tcdm_synch i_synch (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .done_i       (lane_done),
    .done_ready_o (done_ready),
    .synch_o      (synch_o)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, active low reset held for 8 rising edges
 */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== dv/tcdm_mem_model.sv ====
/*
 * TCDM memory model with one read port per lane
 * Random grants and random read latency
 * Read data is derived from the word address
 */
`timescale 1ns/1ns

module tcdm_mem_model #(
  parameter logic [tcdm_pkg::DATA_W-1:0] READ_KEY = '0
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [tcdm_pkg::NUM_LANES-1:0]                      tcdm_req_i,
  input  logic [tcdm_pkg::NUM_LANES-1:0][tcdm_pkg::ADDR_W-1:0] tcdm_add_i,
  output logic [tcdm_pkg::NUM_LANES-1:0]                      tcdm_gnt_o,
  output tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NUM_LANES-1:0]       tcdm_rsp_o
);

  for (genvar k = 0; k < tcdm_pkg::NUM_LANES; k++) begin : g_port
    logic                        gnt_q;
    tcdm_pkg::tcdm_rsp_t         rsp_q;
    logic                        busy_q;
    logic [1:0]                  delay_q;
    logic [tcdm_pkg::ADDR_W-1:0] add_q;

    assign tcdm_gnt_o[k] = gnt_q;
    assign tcdm_rsp_o[k] = rsp_q;

    always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        gnt_q   <= 1'b0;
        rsp_q   <= '0;
        busy_q  <= 1'b0;
        delay_q <= '0;
        add_q   <= '0;
      end else begin
        // Grant about two cycles in three
        gnt_q       <= ($urandom_range(2) != 0);
        rsp_q.valid <= 1'b0;
        if (tcdm_req_i[k] && gnt_q) begin
          busy_q  <= 1'b1;
          delay_q <= 2'($urandom_range(3));
          add_q   <= tcdm_add_i[k];
        end else if (busy_q) begin
          if (delay_q == 2'd0) begin
            busy_q      <= 1'b0;
            rsp_q.valid <= 1'b1;
            rsp_q.rdata <= {{(tcdm_pkg::DATA_W - tcdm_pkg::ADDR_W){1'b0}}, add_q} ^ READ_KEY;
          end else begin
            delay_q <= delay_q - 2'd1;
          end
        end
      end
    end
  end

endmodule

// ==== dv/tcdm_tx_unit_tb.sv ====
/*
 * Testbench of the TCDM transmit unit
 * Random back-to-back commands, random stream grants, long stream stalls
 * Reference word and sid queues, assertions and closing report
 */
`timescale 1ns/1ns

module tcdm_tx_unit_tb;

  localparam int          SEED          = 43948;
  localparam logic [31:0] READ_KEY      = 32'h5A5A0000;
  localparam int          NUM_CMDS      = 40;
  localparam int          ACCEPT_TMO    = 2000;
  localparam int          DRAIN_TMO     = 20000;
  localparam int          RESET_TMO     = 50;
  localparam int          STALL_CYCLES  = 150;

  logic                                                 clk;
  logic                                                 rst_n;
  tcdm_pkg::tx_cmd_t                                    cmd;
  logic                                                 cmd_req;
  logic                                                 cmd_gnt;
  logic [tcdm_pkg::NUM_LANES-1:0]                       tcdm_req;
  logic [tcdm_pkg::NUM_LANES-1:0][tcdm_pkg::ADDR_W-1:0] tcdm_add;
  logic [tcdm_pkg::NUM_LANES-1:0]                       tcdm_gnt;
  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NUM_LANES-1:0]        tcdm_rsp;
  logic [tcdm_pkg::NUM_LANES-1:0][tcdm_pkg::DATA_W-1:0] tx_dat;
  logic [tcdm_pkg::NUM_LANES-1:0]                       tx_req;
  logic [tcdm_pkg::NUM_LANES-1:0]                       tx_gnt;
  tcdm_pkg::synch_t                                     synch;
  logic [tcdm_pkg::NUM_LANES-1:0]                       stall;

  // Reference model state
  logic [31:0]                exp0_q [$];
  logic [31:0]                exp1_q [$];
  logic [tcdm_pkg::SID_W-1:0] sid_q [$];
  int                         end_q [$];
  int                         words_out [tcdm_pkg::NUM_LANES];
  int                         pairs_total = 0;
  int                         cmd_count = 0;
  int                         synch_count = 0;
  int                         mismatches = 0;
  int                         failures = 0;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tcdm_mem_model #(
    .READ_KEY (READ_KEY)
  ) i_mem_model (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .tcdm_req_i (tcdm_req),
    .tcdm_add_i (tcdm_add),
    .tcdm_gnt_o (tcdm_gnt),
    .tcdm_rsp_o (tcdm_rsp)
  );

  tcdm_tx_unit i_tcdm_tx_unit (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .cmd_i         (cmd),
    .cmd_req_i     (cmd_req),
    .cmd_gnt_o     (cmd_gnt),
    .tcdm_req_o    (tcdm_req),
    .tcdm_add_o    (tcdm_add),
    .tcdm_gnt_i    (tcdm_gnt),
    .tcdm_rsp_i    (tcdm_rsp),
    .tx_data_dat_o (tx_dat),
    .tx_data_req_o (tx_req),
    .tx_data_gnt_i (tx_gnt),
    .synch_o       (synch)
  );

  //********************************************************************
  // Reference rules and checks
  //********************************************************************
  function automatic logic [31:0] word_at(input logic [tcdm_pkg::ADDR_W-1:0] a);
    return {{(32 - tcdm_pkg::ADDR_W){1'b0}}, a} ^ READ_KEY;
  endfunction

  function automatic tcdm_pkg::tx_cmd_t random_cmd();
    tcdm_pkg::tx_cmd_t c;
    c.sid = 2'($urandom_range(3));
    c.add = {10'($urandom), 2'b00};
    c.len = 4'($urandom_range(15, 1));
    return c;
  endfunction

  task automatic check_word(input int lane, input logic [31:0] got);
    logic [31:0] exp;
    int          pending;
    pending = (lane == 0) ? exp0_q.size() : exp1_q.size();
    if (pending == 0) begin
      failures++;
      $display("Stream %0d delivered a word at %0t although none was expected", lane, $time);
    end else begin
      if (lane == 0) begin
        exp = exp0_q.pop_front();
      end else begin
        exp = exp1_q.pop_front();
      end
      words_out[lane]++;
      assert (got == exp) else begin
        mismatches++;
        $display("Mismatch at %0t: stream %0d word %h, expected %h", $time, lane, got, exp);
      end
    end
  endtask

  task automatic check_synch(input logic [tcdm_pkg::SID_W-1:0] sid);
    logic [tcdm_pkg::SID_W-1:0] exp_sid;
    int                         end_pairs;
    if (sid_q.size() == 0) begin
      failures++;
      $display("Synch pulse at %0t with no command outstanding", $time);
    end else begin
      exp_sid   = sid_q.pop_front();
      end_pairs = end_q.pop_front();
      synch_count++;
      assert (sid == exp_sid) else begin
        mismatches++;
        $display("Mismatch at %0t: synch sid %0d, expected %0d", $time, sid, exp_sid);
      end
      assert (words_out[0] >= end_pairs && words_out[1] >= end_pairs) else begin
        mismatches++;
        $display("Mismatch at %0t: synch before the last words of its command", $time);
      end
    end
  endtask

  // Monitor of accepted commands, stream words and synch pulses
  always @(posedge clk) begin
    if (rst_n) begin
      if (cmd_req && cmd_gnt) begin
        for (int j = 0; j < int'(cmd.len); j++) begin
          exp0_q.push_back(word_at(cmd.add + 12'(8 * j)));
          exp1_q.push_back(word_at(cmd.add + 12'(8 * j + 4)));
        end
        pairs_total += int'(cmd.len);
        sid_q.push_back(cmd.sid);
        end_q.push_back(pairs_total);
        cmd_count++;
      end
      for (int k = 0; k < tcdm_pkg::NUM_LANES; k++) begin
        if (tx_req[k] && tx_gnt[k]) begin
          check_word(k, tx_dat[k]);
        end
      end
      if (synch.req) begin
        check_synch(synch.sid);
      end
    end
  end

  // Requests hold still until granted
  for (genvar k = 0; k < tcdm_pkg::NUM_LANES; k++) begin : g_port_check
    assert property (@(posedge clk) disable iff (!rst_n)
      (tcdm_req[k] && !tcdm_gnt[k]) |=> (tcdm_req[k] && $stable(tcdm_add[k])))
      else begin
        mismatches++;
        $display("Mismatch at %0t: TCDM request %0d dropped or moved before grant", $time, k);
      end
    assert property (@(posedge clk) disable iff (!rst_n)
      (tx_req[k] && !tx_gnt[k]) |=> (tx_req[k] && $stable(tx_dat[k])))
      else begin
        mismatches++;
        $display("Mismatch at %0t: stream %0d request dropped or moved before grant", $time, k);
      end
  end

  //********************************************************************
  // Stimulus
  //********************************************************************
  // Random stream grants that stop while the stream is stalled
  always @(posedge clk) begin
    for (int k = 0; k < tcdm_pkg::NUM_LANES; k++) begin
      tx_gnt[k] <= rst_n && !stall[k] && ($urandom_range(3) != 0);
    end
  end

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (rst_n !== 1'b1 && cycles < RESET_TMO);
    if (rst_n !== 1'b1) begin
      failures++;
      $display("Reset was not released within %0d cycles", RESET_TMO);
    end
  endtask

  task automatic wait_accept();
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    while (!taken && cycles < ACCEPT_TMO) begin
      @(posedge clk);
      taken = cmd_gnt;
      cycles++;
    end
    if (!taken) begin
      failures++;
      $display("Command was not accepted within %0d cycles", ACCEPT_TMO);
    end
  endtask

  task automatic send_cmd(input tcdm_pkg::tx_cmd_t c);
    cmd     <= c;
    cmd_req <= 1'b1;
    wait_accept();
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while ((exp0_q.size() != 0 || exp1_q.size() != 0 || sid_q.size() != 0) &&
               cycles < DRAIN_TMO);
    if (exp0_q.size() != 0 || exp1_q.size() != 0 || sid_q.size() != 0) begin
      failures++;
      $display("Outstanding words or synch pulses still missing after %0d cycles", DRAIN_TMO);
    end
  endtask

  // Keep offering commands while one stream gets no grant
  task automatic stall_stream(input int lane);
    int last_gnt;
    last_gnt    = -1;
    stall[lane] <= 1'b1;
    cmd         <= random_cmd();
    cmd_req     <= 1'b1;
    for (int i = 0; i < STALL_CYCLES; i++) begin
      @(posedge clk);
      if (cmd_gnt) begin
        last_gnt = i;
        cmd      <= random_cmd();
      end
    end
    if (last_gnt >= STALL_CYCLES - 40) begin
      failures++;
      $display("Command grant was still high late in the stall of stream %0d", lane);
    end
    stall[lane] <= 1'b0;
    wait_accept();
    cmd_req <= 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    cmd     = '0;
    cmd_req = 1'b0;
    tx_gnt  = '0;
    stall   = '0;
    for (int k = 0; k < tcdm_pkg::NUM_LANES; k++) begin
      words_out[k] = 0;
    end

    wait_reset();
    assert (tcdm_req == '0 && tx_req == '0 && !synch.req && cmd_gnt) else begin
      mismatches++;
      $display("Mismatch at %0t: outputs not idle after reset", $time);
    end

    for (int n = 0; n < NUM_CMDS; n++) begin
      send_cmd(random_cmd());
    end
    cmd_req <= 1'b0;
    wait_drained();

    for (int k = 0; k < tcdm_pkg::NUM_LANES; k++) begin
      stall_stream(k);
      wait_drained();
    end

    repeat (5) @(posedge clk);
    assert (synch_count == cmd_count) else begin
      mismatches++;
      $display("Mismatch at %0t: %0d synch pulses for %0d commands", $time, synch_count,
               cmd_count);
    end

    $display("Summary: %0d commands, %0d synch pulses, %0d words, %0d mismatches, %0d other errors",
             cmd_count, synch_count, words_out[0] + words_out[1], mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
source/tcdm_pkg.sv
source/tcdm_fifo.sv
source/tcdm_cmd_unpack.sv
source/tcdm_tx_lane.sv
source/tcdm_synch.sv
source/tcdm_tx_unit.sv
dv/tb_clock_gen.sv
dv/tcdm_mem_model.sv
dv/tcdm_tx_unit_tb.sv

// ==== Makefile ====
# Verilator flow for the TCDM transmit unit
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tcdm_tx_unit_tb
RTL_TOP   ?= tcdm_tx_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The simulator status is ignored, the log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
